/* tests/eeprom_tests.txt */
# name op(W/R) addr(hex) wdata(hex) ack_en exp_rdata(hex) exp_err
# exp_rdata is only checked on reads without an error
w_blk0_a5 W 0a5 3c 1 00 0
w_blk3_a5 W 3a5 c7 1 00 0
w_blk7_a5 W 7a5 81 1 00 0
r_blk0_a5 R 0a5 00 1 3c 0
r_blk3_a5 R 3a5 00 1 c7 0
r_blk7_a5 R 7a5 00 1 81 0
w_blk0_00 W 000 5a 1 00 0
w_blk0_ff W 0ff a5 1 00 0
r_blk0_00 R 000 00 1 5a 0
r_blk0_ff R 0ff 00 1 a5 0
w_nack W 123 99 0 00 1
r_nack R 3a5 00 0 00 1
r_after_nack R 3a5 00 1 c7 0
w_blk3_a5_over W 3a5 12 1 00 0
r_blk3_a5_new R 3a5 00 1 12 0
r_blk0_a5_again R 0a5 00 1 3c 0
w_blk5_7e W 57e e1 1 00 0
r_blk5_7e R 57e 00 1 e1 0
w_blk5_7e_ones W 57e ff 1 00 0
r_blk5_7e_ones R 57e 00 1 ff 0

/* sim.f */
common/eeprom_pkg.sv
hw/host_port.sv
i2c_master/byte_sequencer.sv
i2c_master/bit_engine.sv
hw/eeprom_ctrl_top.sv
tests/eeprom_model.sv
tests/tb_eeprom_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_eeprom_ctrl
CLK_DIV   ?= 4
SIMFLAGS  ?=

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f sim.f --top-module $(TOP) \
		-GCLK_DIV=$(CLK_DIV) $(SIMFLAGS)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "test passed"

lint:
	$(VERILATOR) --lint-only --timing -f sim.f --top-module $(TOP) \
		-GCLK_DIV=$(CLK_DIV) $(SIMFLAGS)

clean:
	rm -rf obj_dir

/* tests/tb_eeprom_ctrl.sv */
`timescale 1ns/10ps

module tb_eeprom_ctrl #(
    parameter int CLK_DIV = 4
);

    logic                   CLK;
    logic                   RESET;
    logic                   req;
    logic                   rd;
    eeprom_pkg::mem_addr_t  addr;
    eeprom_pkg::data_byte_t wdata;
    logic                   ack;
    eeprom_pkg::data_byte_t rdata;
    logic                   nack_err;
    logic                   scl;
    logic                   sda_low;
    logic                   model_sda_low;
    logic                   model_ack_en;
    logic                   sda;

    string       t_name [0:63];
    logic        t_rd [0:63];
    logic [10:0] t_addr [0:63];
    logic [7:0]  t_wdata [0:63];
    logic        t_acken [0:63];
    logic [7:0]  t_exp_rd [0:63];
    logic        t_exp_err [0:63];
    int          n_ops;
    int          errors;
    int          cycles;
    int          limit;
    int          starts;
    int          stops;
    logic        mon_scl;
    logic        mon_sda;

    assign sda = !(sda_low || model_sda_low); // wired-AND, pulled up

    eeprom_ctrl_top #(.CLK_DIV(CLK_DIV)) u_dut (
        .CLK(CLK), .RESET(RESET), .req(req), .rd(rd), .addr(addr), .wdata(wdata),
        .ack(ack), .rdata(rdata), .nack_err(nack_err), .scl(scl),
        .sda_low(sda_low), .sda_in(sda)
    );

    eeprom_model u_model (
        .CLK(CLK), .RESET(RESET), .scl(scl), .sda(sda), .ack_en(model_ack_en),
        .sda_low(model_sda_low)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    // bus monitor, counts start and stop conditions
    always @(posedge CLK) begin
        mon_scl <= scl;
        mon_sda <= sda;
        if (!RESET && scl && mon_scl && mon_sda && !sda)
            starts <= starts + 1;
        if (!RESET && scl && mon_scl && !mon_sda && sda)
            stops <= stops + 1;
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout reached after %0d cycles without finishing all operations",
                     cycles);
            $display("test failed");
            $finish;
        end
    end

    task automatic compare_val(input string tname, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERR %s %s expected %0h actual %0h", tname, field, exp, act);
            errors++;
        end
    endtask

    task automatic load_tests();
        int    fd;
        int    cnt;
        string op;
        reg [8*160-1:0] line_buf;
        n_ops = 0;
        fd = $fopen("tests/eeprom_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the data file tests/eeprom_tests.txt");
        end else begin
            while (!$feof(fd) && n_ops < 64) begin
                line_buf = '0;
                void'($fgets(line_buf, fd));
                cnt = $sscanf(line_buf, "%s %s %h %h %d %h %d", t_name[n_ops], op,
                              t_addr[n_ops], t_wdata[n_ops], t_acken[n_ops],
                              t_exp_rd[n_ops], t_exp_err[n_ops]);
                if (cnt == 7) begin
                    t_rd[n_ops] = (op == "R");
                    n_ops++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_op(input int i);
        int s0;
        int p0;
        s0 = starts;
        p0 = stops;
        rd           = t_rd[i];
        addr         = t_addr[i];
        wdata        = t_wdata[i];
        model_ack_en = t_acken[i];
        @(negedge CLK);
        compare_val(t_name[i], "ack_before_req", 0, ack);
        req = 1'b1;
        while (!ack)
            @(negedge CLK);
        compare_val(t_name[i], "nack_err", t_exp_err[i], nack_err);
        if (t_rd[i] && !t_exp_err[i])
            compare_val(t_name[i], "rdata", t_exp_rd[i], rdata);
        compare_val(t_name[i], "scl_idle", 1, scl);
        compare_val(t_name[i], "sda_idle", 1, sda);
        compare_val(t_name[i], "starts", (t_rd[i] && !t_exp_err[i]) ? 2 : 1, starts - s0);
        compare_val(t_name[i], "stops", 1, stops - p0);
        repeat (3) @(negedge CLK);
        compare_val(t_name[i], "ack_held", 1, ack); // ack waits for req to fall
        req = 1'b0;
        while (ack)
            @(negedge CLK);
    endtask

    initial begin
        RESET        = 1'b1;
        req          = 1'b0;
        rd           = 1'b0;
        addr         = '0;
        wdata        = '0;
        model_ack_en = 1'b1;
        errors       = 0;
        cycles       = 0;
        limit        = 0;
        starts       = 0;
        stops        = 0;
        load_tests();
        if (n_ops == 0) begin
            $display("the data file holds no operations");
            errors++;
        end
        limit = n_ops * (44 * 9 * CLK_DIV + 100);
        repeat (4) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        compare_val("reset", "ack", 0, ack);
        for (int i = 0; i < n_ops; i++)
            run_op(i);
        $display("operations %0d, errors %0d", n_ops, errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* tests/eeprom_model.sv */
`timescale 1ns/10ps

module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,    // resolved bus level
    input  logic ack_en, // 0 leaves every byte unacknowledged
    output logic sda_low
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_WADDR,
        M_WDATA,
        M_READ,
        M_IGNORE
    } model_mode_t;

    eeprom_pkg::data_byte_t mem [0:2047];
    eeprom_pkg::mem_addr_t  ptr;
    eeprom_pkg::data_byte_t sh;
    model_mode_t            mode;
    logic [3:0]             bitn;
    logic                   prev_scl;
    logic                   prev_sda;
    logic                   receiving;
    logic                   start_fall; // next scl fall closes a start

    // fill pattern mixes block and word address
    initial begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i ^ (i >> 3) ^ 8'h5c);
    end

    assign receiving = (mode == M_CTRL) || (mode == M_WADDR) || (mode == M_WDATA);

    always @(posedge CLK) begin
        prev_scl <= scl;
        prev_sda <= sda;
        if (RESET) begin
            mode       <= M_IDLE;
            bitn       <= 4'd0;
            sda_low    <= 1'b0;
            ptr        <= '0;
            start_fall <= 1'b0;
        end else if (scl && prev_scl && prev_sda && !sda) begin
            mode       <= M_CTRL; // start or repeated start
            bitn       <= 4'd0;
            sda_low    <= 1'b0;
            start_fall <= 1'b1;
        end else if (scl && prev_scl && !prev_sda && sda) begin
            mode    <= M_IDLE; // stop
            sda_low <= 1'b0;
        end else if (scl && !prev_scl) begin
            if (receiving && bitn < 4'd8)
                sh <= {sh[6:0], sda};
        end else if (!scl && prev_scl && mode != M_IDLE && mode != M_IGNORE) begin
            if (start_fall) begin
                start_fall <= 1'b0; // no data bit before this fall
            end else if (bitn < 4'd7) begin
                bitn <= bitn + 4'd1;
                if (mode == M_READ) begin
                    sda_low <= !sh[6];
                    sh      <= {sh[6:0], 1'b0};
                end
            end else if (bitn == 4'd7) begin
                bitn    <= 4'd8;
                sda_low <= receiving && ack_en; // ack slot, master acks reads
            end else begin
                bitn    <= 4'd0;
                sda_low <= 1'b0;
                case (mode)
                    M_CTRL:
                        if (!ack_en || sh[7:4] != eeprom_pkg::DEV_CODE) begin
                            mode <= M_IGNORE;
                        end else if (sh[0]) begin
                            mode    <= M_READ;
                            sh      <= mem[ptr];
                            sda_low <= !mem[ptr][7];
                        end else begin
                            ptr[10:8] <= sh[3:1];
                            mode      <= M_WADDR;
                        end
                    M_WADDR: begin
                        ptr[7:0] <= sh;
                        mode     <= ack_en ? M_WDATA : M_IGNORE;
                    end
                    M_WDATA: begin
                        if (ack_en)
                            mem[ptr] <= sh;
                        ptr[7:0] <= ptr[7:0] + 8'd1;
                    end
                    default: mode <= M_IGNORE; // single byte read done
                endcase
            end
        end
    end

endmodule

/* hw/eeprom_ctrl_top.sv */
`timescale 1ns/10ps

module eeprom_ctrl_top #(
    parameter int CLK_DIV = 4
) (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   req,
    input  logic                   rd,
    input  eeprom_pkg::mem_addr_t  addr,
    input  eeprom_pkg::data_byte_t wdata,
    output logic                   ack,
    output eeprom_pkg::data_byte_t rdata,
    output logic                   nack_err,
    output logic                   scl,
    output logic                   sda_low,
    input  logic                   sda_in
);

    logic                   txn_start;
    logic                   txn_rd;
    eeprom_pkg::mem_addr_t  txn_addr;
    eeprom_pkg::data_byte_t txn_wdata;
    logic                   txn_done;
    eeprom_pkg::data_byte_t txn_rdata;
    logic                   txn_nack;

    logic                   cmd_go;
    eeprom_pkg::bit_cmd_t   cmd;
    eeprom_pkg::data_byte_t tx_byte;
    logic                   tx_ack_bit;
    logic                   busy;
    logic                   cmd_done;
    eeprom_pkg::data_byte_t rx_byte;
    logic                   rx_ack;

    host_port u_host (
        .CLK(CLK), .RESET(RESET), .req(req), .rd(rd), .addr(addr), .wdata(wdata),
        .ack(ack), .rdata(rdata), .nack_err(nack_err),
        .txn_start(txn_start), .txn_rd(txn_rd), .txn_addr(txn_addr),
        .txn_wdata(txn_wdata), .txn_done(txn_done), .txn_rdata(txn_rdata),
        .txn_nack(txn_nack)
    );

    byte_sequencer u_seq (
        .CLK(CLK), .RESET(RESET), .txn_start(txn_start), .txn_rd(txn_rd),
        .txn_addr(txn_addr), .txn_wdata(txn_wdata), .txn_done(txn_done),
        .txn_rdata(txn_rdata), .txn_nack(txn_nack), .cmd_go(cmd_go), .cmd(cmd),
        .tx_byte(tx_byte), .tx_ack_bit(tx_ack_bit), .busy(busy),
        .cmd_done(cmd_done), .rx_byte(rx_byte), .rx_ack(rx_ack)
    );

    bit_engine #(.CLK_DIV(CLK_DIV)) u_bit (
        .CLK(CLK), .RESET(RESET), .cmd_go(cmd_go), .cmd(cmd), .tx_byte(tx_byte),
        .tx_ack_bit(tx_ack_bit), .busy(busy), .cmd_done(cmd_done),
        .rx_byte(rx_byte), .rx_ack(rx_ack), .scl(scl), .sda_low(sda_low),
        .sda_in(sda_in)
    );

endmodule

/* i2c_master/bit_engine.sv */
`timescale 1ns/10ps

module bit_engine #(
    parameter int CLK_DIV = 4
) (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   cmd_go,
    input  eeprom_pkg::bit_cmd_t   cmd,
    input  eeprom_pkg::data_byte_t tx_byte,
    input  logic                   tx_ack_bit,
    output logic                   busy,
    output logic                   cmd_done,
    output eeprom_pkg::data_byte_t rx_byte,
    output logic                   rx_ack,
    output logic                   scl,
    output logic                   sda_low,
    input  logic                   sda_in
);

    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    typedef enum logic [1:0] {
        B_IDLE,
        B_START,
        B_STOP,
        B_BYTE
    } bit_state_t;

    bit_state_t             st;
    logic [DIV_W-1:0]       div_cnt;
    logic [1:0]             phase;   // 0 low, 1 rise, 2 high, 3 fall
    logic [3:0]             bit_cnt; // 8 is the ack slot
    logic                   is_read;
    logic                   ack_out;
    eeprom_pkg::data_byte_t tx_sh;
    logic                   tick;
    logic                   scl_nxt;
    logic                   sda_low_nxt;

    assign tick = (div_cnt == DIV_W'(CLK_DIV - 1));

    always_comb begin
        scl_nxt     = (phase == 2'd1) || (phase == 2'd2);
        sda_low_nxt = 1'b0;
        case (st)
            B_START: sda_low_nxt = (phase >= 2'd2); // falls while scl high
            B_STOP: begin
                scl_nxt     = (phase != 2'd0);
                sda_low_nxt = (phase <= 2'd1); // released while scl high
            end
            B_BYTE:
                if (bit_cnt < 4'd8)
                    sda_low_nxt = !is_read && !tx_sh[7];
                else
                    sda_low_nxt = is_read && !ack_out;
            default: begin
                scl_nxt     = scl; // hold the line between commands
                sda_low_nxt = sda_low;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            st       <= B_IDLE;
            busy     <= 1'b0;
            cmd_done <= 1'b0;
            scl      <= 1'b1;
            sda_low  <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            scl      <= scl_nxt;
            sda_low  <= sda_low_nxt;
            if (st == B_IDLE) begin
                if (cmd_go) begin
                    busy    <= 1'b1;
                    div_cnt <= '0;
                    phase   <= 2'd0;
                    bit_cnt <= 4'd0;
                    is_read <= (cmd == eeprom_pkg::CMD_READ);
                    ack_out <= tx_ack_bit;
                    tx_sh   <= tx_byte;
                    case (cmd)
                        eeprom_pkg::CMD_START: st <= B_START;
                        eeprom_pkg::CMD_STOP:  st <= B_STOP;
                        default:               st <= B_BYTE;
                    endcase
                end
            end else if (!tick) begin
                div_cnt <= div_cnt + 1'b1;
            end else begin
                div_cnt <= '0;
                phase   <= phase + 2'd1;
                if (st == B_BYTE && phase == 2'd2) begin
                    if (bit_cnt < 4'd8)
                        rx_byte <= {rx_byte[6:0], sda_in};
                    else
                        rx_ack <= sda_in; // high means no ack
                end
                if (phase == 2'd3) begin
                    if (st != B_BYTE || bit_cnt == 4'd8) begin
                        st       <= B_IDLE;
                        busy     <= 1'b0;
                        cmd_done <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                        tx_sh   <= {tx_sh[6:0], 1'b0};
                    end
                end
            end
        end
    end

    // data bits and ack stay put across the whole scl high time
    assert property (@(posedge CLK) disable iff (RESET)
        (st == B_BYTE && scl && $past(scl)) |-> $stable(sda_low));

endmodule

/* i2c_master/byte_sequencer.sv */
`timescale 1ns/10ps

module byte_sequencer (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   txn_start,
    input  logic                   txn_rd,
    input  eeprom_pkg::mem_addr_t  txn_addr,
    input  eeprom_pkg::data_byte_t txn_wdata,
    output logic                   txn_done,
    output eeprom_pkg::data_byte_t txn_rdata,
    output logic                   txn_nack,
    output logic                   cmd_go,
    output eeprom_pkg::bit_cmd_t   cmd,
    output eeprom_pkg::data_byte_t tx_byte,
    output logic                   tx_ack_bit,
    input  logic                   busy,
    input  logic                   cmd_done,
    input  eeprom_pkg::data_byte_t rx_byte,
    input  logic                   rx_ack
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_WADDR,
        S_WDATA,
        S_RSTART,
        S_CTRL_R,
        S_RDATA,
        S_STOP
    } seq_state_t;

    seq_state_t state;
    seq_state_t next_state;
    logic       waiting;   // command issued, cmd_done not yet seen
    logic       check_ack; // state writes a byte the slave must ack

    eeprom_pkg::bit_cmd_t   cmd_sel;
    eeprom_pkg::data_byte_t byte_sel;

    always_comb begin
        cmd_sel    = eeprom_pkg::CMD_START;
        byte_sel   = txn_wdata;
        next_state = S_IDLE;
        check_ack  = 1'b0;
        case (state)
            S_START: next_state = S_CTRL_W;
            S_CTRL_W: begin
                cmd_sel    = eeprom_pkg::CMD_WRITE;
                byte_sel   = {eeprom_pkg::DEV_CODE, txn_addr[10:8], eeprom_pkg::RW_WRITE};
                next_state = S_WADDR;
                check_ack  = 1'b1;
            end
            S_WADDR: begin
                cmd_sel    = eeprom_pkg::CMD_WRITE;
                byte_sel   = txn_addr[7:0];
                next_state = txn_rd ? S_RSTART : S_WDATA;
                check_ack  = 1'b1;
            end
            S_WDATA: begin
                cmd_sel    = eeprom_pkg::CMD_WRITE;
                next_state = S_STOP;
                check_ack  = 1'b1;
            end
            S_RSTART: next_state = S_CTRL_R;
            S_CTRL_R: begin
                cmd_sel    = eeprom_pkg::CMD_WRITE;
                byte_sel   = {eeprom_pkg::DEV_CODE, txn_addr[10:8], eeprom_pkg::RW_READ};
                next_state = S_RDATA;
                check_ack  = 1'b1;
            end
            S_RDATA: begin
                cmd_sel    = eeprom_pkg::CMD_READ;
                next_state = S_STOP;
            end
            S_STOP: cmd_sel = eeprom_pkg::CMD_STOP;
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= S_IDLE;
            waiting  <= 1'b0;
            cmd_go   <= 1'b0;
            txn_done <= 1'b0;
            txn_nack <= 1'b0;
        end else begin
            cmd_go   <= 1'b0;
            txn_done <= 1'b0;
            if (state == S_IDLE) begin
                if (txn_start) begin
                    txn_nack <= 1'b0;
                    waiting  <= 1'b0;
                    state    <= S_START;
                end
            end else if (!waiting) begin
                if (!busy) begin
                    cmd_go     <= 1'b1;
                    cmd        <= cmd_sel;
                    tx_byte    <= byte_sel;
                    tx_ack_bit <= eeprom_pkg::NACK_BIT; // single byte read ends with nack
                    waiting    <= 1'b1;
                end
            end else if (cmd_done) begin
                waiting <= 1'b0;
                if (state == S_RDATA)
                    txn_rdata <= rx_byte;
                if (state == S_STOP)
                    txn_done <= 1'b1;
                if (check_ack && rx_ack) begin
                    txn_nack <= 1'b1; // no ack, abort to stop
                    state    <= S_STOP;
                end else begin
                    state <= next_state;
                end
            end
        end
    end

    assert property (@(posedge CLK) disable iff (RESET) cmd_go |-> !busy);

endmodule

/* hw/host_port.sv */
`timescale 1ns/10ps

module host_port (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   req,
    input  logic                   rd,
    input  eeprom_pkg::mem_addr_t  addr,
    input  eeprom_pkg::data_byte_t wdata,
    output logic                   ack,
    output eeprom_pkg::data_byte_t rdata,
    output logic                   nack_err,
    output logic                   txn_start,
    output logic                   txn_rd,
    output eeprom_pkg::mem_addr_t  txn_addr,
    output eeprom_pkg::data_byte_t txn_wdata,
    input  logic                   txn_done,
    input  eeprom_pkg::data_byte_t txn_rdata,
    input  logic                   txn_nack
);

    typedef enum logic [1:0] {
        H_IDLE,
        H_BUSY,
        H_ACKED
    } host_state_t;

    host_state_t state;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= H_IDLE;
            ack       <= 1'b0;
            txn_start <= 1'b0;
        end else begin
            txn_start <= 1'b0;
            case (state)
                H_IDLE: if (req) begin
                    txn_rd    <= rd;
                    txn_addr  <= addr;
                    txn_wdata <= wdata;
                    txn_start <= 1'b1;
                    state     <= H_BUSY;
                end
                H_BUSY: if (txn_done) begin
                    rdata    <= txn_rdata; // held until the next request
                    nack_err <= txn_nack;
                    ack      <= 1'b1;
                    state    <= H_ACKED;
                end
                H_ACKED: if (!req) begin
                    ack   <= 1'b0;
                    state <= H_IDLE;
                end
                default: state <= H_IDLE;
            endcase
        end
    end

    // host must keep req up until it has seen ack
    assert property (@(posedge CLK) disable iff (RESET) state == H_BUSY |-> req);

endmodule

/* common/eeprom_pkg.sv */
package eeprom_pkg;

    // 2 KB array, block in the upper three bits
    localparam int ADDR_W = 11;
    localparam int BLK_W  = 3;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] mem_addr_t;
    typedef logic [DATA_W-1:0] data_byte_t;
    typedef logic [1:0]        bit_cmd_t;

    // bit engine commands
    localparam bit_cmd_t CMD_START = 2'd0; // also repeated start
    localparam bit_cmd_t CMD_STOP  = 2'd1;
    localparam bit_cmd_t CMD_WRITE = 2'd2;
    localparam bit_cmd_t CMD_READ  = 2'd3;

    // device type code for 24Cxx parts
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // r/w bit at the bottom of the control byte
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    // master ack level after the last read byte
    localparam logic NACK_BIT = 1'b1;

endpackage
